// File: flist.f
source/uart_pkg.sv
source/hand_pkg.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/coord_framer.sv
source/coord_deframer.sv
source/seven_segment_controller.sv
source/hand_link_top.sv
dv/hand_link_checker.sv
dv/hand_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= hand_link_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_MSG ?= Errors found
PASS_MSG ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/hand_link_tb.sv
`default_nettype none

module hand_link_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import uart_pkg::*;
  import hand_pkg::*;

  typedef enum logic [1:0] {
    k_loop, // framer out on txd, back in on rxd
    k_backp, // second send while the first frame is busy
    k_inject // frame bit-banged onto rxd
  } kind_t;

  typedef struct packed {
    kind_t kind;
    logic corrupt; // flip bit 0 of the checksum
    logic junk; // junk bytes ahead of the header
    hand_coord_t coord;
  } row_t;

  logic clk_65mhz, rst_n, send, txd, tx_busy, hand_valid, frame_error;
  logic rxd;
  logic loop_sel; // 1 feeds txd back, 0 takes the bit-banger
  logic bang_line;
  hand_coord_t hand_in, hand_out;
  hand_coord_t hv_last; // hand_out captured on the last hand_valid
  hand_coord_t exp_shown; // last good coordinate sent
  logic [6:0] cat;
  logic [7:0] an;
  logic [31:0] lfsr_q = 32'hb7b18ceb;
  int hv_cnt = 0;
  int fe_cnt = 0;
  int err_cnt = 0;
  int fail_cnt = 0;
  int test_cnt = 0;
  string names [9];
  row_t rows [9];
  // hex digits, segments g..a, lit = 1
  logic [6:0] seg_hex [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                               7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

  assign rxd = loop_sel ? txd : bang_line;

  hand_link_top #(.clks_per_bit(16)) i_hand_link_top (
    .clk_65mhz(clk_65mhz),
    .rst_n(rst_n),
    .send(send),
    .rxd(rxd),
    .hand_in(hand_in),
    .txd(txd),
    .tx_busy(tx_busy),
    .hand_valid(hand_valid),
    .frame_error(frame_error),
    .hand_out(hand_out),
    .cat(cat),
    .an(an)
  );

  bind hand_link_top hand_link_checker i_hand_link_checker (
    .clk_65mhz(clk_65mhz),
    .rst_n(rst_n),
    .hand_valid(hand_valid),
    .frame_error(frame_error),
    .txd(txd),
    .tx_busy(tx_busy)
  );

  initial begin
    clk_65mhz = 1'b0;
    forever #50 clk_65mhz = ~clk_65mhz;
  end

  // strobe counters, sampled like a flop would
  always @(posedge clk_65mhz) begin
    if (hand_valid) begin
      hv_cnt <= hv_cnt + 1;
      hv_last <= hand_out;
    end
    if (frame_error) fe_cnt <= fe_cnt + 1;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic hand_coord_t rand_coord();
    logic [25:0] r;
    r = '0;
    for (int i = 0; i < 26; i++) begin
      lfsr_q = lfsr_next(lfsr_q); // one step per bit
      r = {r[24:0], lfsr_q[0]};
    end
    return hand_coord_t'(r);
  endfunction

  // header first in [7:0], checksum last in [47:40]
  function automatic logic [47:0] frame_bytes(input hand_coord_t c, input logic corrupt);
    logic [7:0] p0, p1, p2, p3, ck;
    p0 = {4'h0, c.y[11:8]};
    p1 = c.y[7:0];
    p2 = {2'b00, c.z[13:8]};
    p3 = c.z[7:0];
    ck = p0 ^ p1 ^ p2 ^ p3 ^ {7'd0, corrupt};
    return {ck, p3, p2, p1, p0, 8'hA5};
  endfunction

  task automatic check_eq(input string name, input string what,
                          input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
      else begin
        $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
        err_cnt++;
      end
  endtask

  task automatic report_test(input string name, input int err0);
    test_cnt++;
    if (err_cnt != err0) fail_cnt++;
    $display("test %-10s %s", name, (err_cnt == err0) ? "ok" : "failed");
  endtask

  // 8N1 at 16 cycles per bit, lsb first
  task automatic bang_byte(input uart_byte_t b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      bang_line = bits[i];
      repeat (16) @(negedge clk_65mhz);
    end
    repeat (2) @(negedge clk_65mhz); // short idle gap
  endtask

  task automatic wait_busy(input logic level, input string name);
    int n;
    n = 0;
    while (tx_busy !== level && n < 3000) begin
      @(negedge clk_65mhz);
      n++;
    end
    if (tx_busy !== level) begin
      $display("timeout in test %s, tx_busy never went to %0b", name, level);
      err_cnt++;
    end
  endtask

  task automatic wait_result(input int hv0, input int fe0, input string name);
    int n;
    n = 0;
    while (hv_cnt == hv0 && fe_cnt == fe0 && n < 4000) begin
      @(negedge clk_65mhz);
      n++;
    end
    if (hv_cnt == hv0 && fe_cnt == fe0) begin
      $display("timeout in test %s, no hand_valid or frame_error arrived", name);
      err_cnt++;
    end
  endtask

  task automatic check_reset_state();
    int err0;
    err0 = err_cnt;
    for (int i = 0; i < 200; i++) begin
      @(negedge clk_65mhz);
      check_eq("reset", "{txd,tx_busy,hand_valid,frame_error}", 32'h8,
               {28'd0, txd, tx_busy, hand_valid, frame_error});
      check_eq("reset", "an", 32'hff, {24'd0, an}); // all digits off before the scan starts
    end
    report_test("reset", err0);
  endtask

  task automatic run_row(input int i);
    int hv0, fe0, err0;
    logic [47:0] frame;
    uart_byte_t junk [4] = '{8'h00, 8'h5a, 8'hff, 8'h3c}; // none is the header
    hv0 = hv_cnt;
    fe0 = fe_cnt;
    err0 = err_cnt;
    loop_sel = (rows[i].kind != k_inject);
    if (loop_sel) begin
      hand_in = rows[i].coord;
      send = 1'b1;
      @(negedge clk_65mhz);
      send = 1'b0;
      if (rows[i].kind == k_backp) begin
        wait_busy(1'b1, names[i]);
        hand_in = hand_coord_t'(~rows[i].coord); // must be dropped
        send = 1'b1;
        @(negedge clk_65mhz);
        send = 1'b0;
      end
    end else begin
      if (rows[i].junk) foreach (junk[j]) bang_byte(junk[j]);
      frame = frame_bytes(rows[i].coord, rows[i].corrupt);
      for (int b = 0; b < 6; b++) bang_byte(frame[8*b +: 8]);
    end
    wait_result(hv0, fe0, names[i]);
    wait_busy(1'b0, names[i]);
    repeat (1500) @(negedge clk_65mhz); // room for a stray second frame
    if (rows[i].corrupt) begin
      check_eq(names[i], "frame_error pulses", 32'd1, fe_cnt - fe0);
      check_eq(names[i], "hand_valid pulses", 32'd0, hv_cnt - hv0);
    end else begin
      check_eq(names[i], "hand_valid pulses", 32'd1, hv_cnt - hv0);
      check_eq(names[i], "frame_error pulses", 32'd0, fe_cnt - fe0);
      check_eq(names[i], "hand_out", 32'(rows[i].coord), 32'(hv_last));
      exp_shown = rows[i].coord;
    end
    check_eq(names[i], "held coordinate", 32'(exp_shown), 32'(i_hand_link_top.shown));
    report_test(names[i], err0);
  endtask

  task automatic check_display();
    logic [31:0] disp;
    logic [6:0] exp_cat;
    int n, err0;
    err0 = err_cnt;
    disp = {4'h0, exp_shown.y, 2'b00, exp_shown.z};
    for (int k = 0; k < 8; k++) begin
      n = 0;
      while (an !== ~(8'd1 << k) && n < 9000) begin
        @(negedge clk_65mhz);
        n++;
      end
      if (an !== ~(8'd1 << k)) begin
        $display("timeout in test display, anode %0d never went low alone", k);
        err_cnt++;
      end else begin
        exp_cat = ~seg_hex[disp[4*k +: 4]]; // cathodes are active low
        check_eq("display", $sformatf("cat of digit %0d", k), 32'(exp_cat), 32'(cat));
      end
    end
    report_test("display", err0);
  endtask

  initial begin
    rst_n = 1'b0;
    send = 1'b0;
    hand_in = '0;
    loop_sel = 1'b1;
    bang_line = 1'b1;
    exp_shown = '0;
    names[0] = "zeros";
    rows[0] = '{k_loop, 1'b0, 1'b0, hand_coord_t'(26'h0)};
    names[1] = "ones";
    rows[1] = '{k_loop, 1'b0, 1'b0, hand_coord_t'(26'h3ffffff)};
    names[2] = "alternate";
    rows[2] = '{k_loop, 1'b0, 1'b0, hand_coord_t'({12'haaa, 14'h1555})};
    names[3] = "rand_a";
    rows[3] = '{k_loop, 1'b0, 1'b0, rand_coord()};
    names[4] = "rand_b";
    rows[4] = '{k_loop, 1'b0, 1'b0, rand_coord()};
    names[5] = "backpress";
    rows[5] = '{k_backp, 1'b0, 1'b0, rand_coord()};
    names[6] = "inject";
    rows[6] = '{k_inject, 1'b0, 1'b0, rand_coord()};
    names[7] = "bad_cksum";
    rows[7] = '{k_inject, 1'b1, 1'b0, rand_coord()};
    names[8] = "resync";
    rows[8] = '{k_inject, 1'b0, 1'b1, rand_coord()};
    repeat (8) @(negedge clk_65mhz);
    rst_n = 1'b1;
    check_reset_state();
    for (int i = 0; i < 9; i++) run_row(i);
    check_display(); // shows the resync coordinate
    err_cnt += i_hand_link_top.i_hand_link_checker.assert_fails; // bound assertion failures
    $display("tests %0d, failed %0d, check errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/hand_link_checker.sv
`default_nettype none

module hand_link_checker (
  input wire clk_65mhz,
  input wire rst_n,
  input wire hand_valid,
  input wire frame_error,
  input wire txd,
  input wire tx_busy
);
  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0; // failed assertion count

  // a frame ends either good or bad, never both
  a_result_exclusive: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
    !(hand_valid && frame_error))
    else begin
      $error("hand_valid and frame_error high in the same cycle");
      assert_fails++;
    end

  a_valid_one_cycle: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
    hand_valid |=> !hand_valid)
    else begin
      $error("hand_valid held longer than one cycle");
      assert_fails++;
    end

  a_error_one_cycle: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
    frame_error |=> !frame_error)
    else begin
      $error("frame_error held longer than one cycle");
      assert_fails++;
    end

  // serial line must idle high between frames
  a_idle_line: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
    !tx_busy |-> txd)
    else begin
      $error("txd low while tx_busy is low");
      assert_fails++;
    end

endmodule

`default_nettype wire

// File: source/hand_link_top.sv
`default_nettype none

module hand_link_top #(
  parameter int clks_per_bit = uart_pkg::clks_per_bit_default
) (
  input wire clk_65mhz,
  input wire rst_n,
  input wire send, // transmit hand_in as one frame
  input wire rxd,
  input wire hand_pkg::hand_coord_t hand_in,
  output logic txd,
  output logic tx_busy, // high for the whole outgoing frame
  output logic hand_valid,
  output logic frame_error,
  output hand_pkg::hand_coord_t hand_out,
  output logic [6:0] cat,
  output logic [7:0] an
);
  import uart_pkg::*;
  import hand_pkg::*;

  logic tx_start;
  uart_byte_t tx_data;
  logic byte_busy; // per-byte busy, tx_busy spans the frame
  uart_byte_t rx_data;
  logic rx_valid;
  hand_coord_t shown;

  // transmit side
  coord_framer i_coord_framer (
    .clk_65mhz(clk_65mhz),
    .rst_n(rst_n),
    .send(send),
    .hand_in(hand_in),
    .byte_busy(byte_busy),
    .tx_start(tx_start),
    .tx_data(tx_data),
    .frame_busy(tx_busy)
  );

  uart_transmitter #(.clks_per_bit(clks_per_bit)) i_uart_transmitter (
    .clk_65mhz(clk_65mhz),
    .rst_n(rst_n),
    .tx_start(tx_start),
    .tx_data(tx_data),
    .txd(txd),
    .tx_busy(byte_busy)
  );

  // receive side
  uart_receiver #(.clks_per_bit(clks_per_bit)) i_uart_receiver (
    .clk_65mhz(clk_65mhz),
    .rst_n(rst_n),
    .rxd(rxd),
    .rx_data(rx_data),
    .rx_valid(rx_valid)
  );

  coord_deframer i_coord_deframer (
    .clk_65mhz(clk_65mhz),
    .rst_n(rst_n),
    .rx_valid(rx_valid),
    .rx_data(rx_data),
    .hand_out(hand_out),
    .hand_valid(hand_valid),
    .frame_error(frame_error),
    .shown(shown)
  );

  seven_segment_controller i_seven_segment_controller (
    .clk_65mhz(clk_65mhz),
    .rst_n(rst_n),
    .shown(shown),
    .cat(cat), // {g,f,e,d,c,b,a}
    .an(an)
  );

endmodule

`default_nettype wire

// File: source/seven_segment_controller.sv
`default_nettype none

module seven_segment_controller (
  input wire clk_65mhz,
  input wire rst_n,
  input wire hand_pkg::hand_coord_t shown,
  output logic [6:0] cat, // g..a, low lights a segment
  output logic [7:0] an // low enables a digit
);

  logic [9:0] prescale; // 1024 cycles per digit
  logic [2:0] digit; // digit currently lit
  logic scan_on; // blank until the first step
  logic [31:0] disp;
  logic [3:0] nibble;
  logic [6:0] seg_on; // active high pattern

  // top digit always reads 0, z gets two pad bits
  assign disp = {4'h0, shown.y, 2'b00, shown.z};
  assign nibble = disp[{digit, 2'b00} +: 4];
  assign an = scan_on ? ~(8'd1 << digit) : 8'hff;
  assign cat = ~seg_on;

  always_comb begin
    case (nibble)
      4'h0: seg_on = 7'b0111111;
      4'h1: seg_on = 7'b0000110;
      4'h2: seg_on = 7'b1011011;
      4'h3: seg_on = 7'b1001111;
      4'h4: seg_on = 7'b1100110;
      4'h5: seg_on = 7'b1101101;
      4'h6: seg_on = 7'b1111101;
      4'h7: seg_on = 7'b0000111;
      4'h8: seg_on = 7'b1111111;
      4'h9: seg_on = 7'b1101111;
      4'ha: seg_on = 7'b1110111;
      4'hb: seg_on = 7'b1111100; // lower case b
      4'hc: seg_on = 7'b0111001;
      4'hd: seg_on = 7'b1011110; // lower case d
      4'he: seg_on = 7'b1111001;
      default: seg_on = 7'b1110001; // F
    endcase
  end

  always_ff @(posedge clk_65mhz or negedge rst_n) begin
    if (!rst_n) begin
      prescale <= '0;
      digit <= '0;
      scan_on <= 1'b0;
    end else begin
      prescale <= prescale + 1'b1;
      if (&prescale) begin
        scan_on <= 1'b1;
        if (scan_on) digit <= digit + 1'b1; // first step lights digit 0
      end
    end
  end

endmodule

`default_nettype wire

// File: source/coord_deframer.sv
`default_nettype none

module coord_deframer (
  input wire clk_65mhz,
  input wire rst_n,
  input wire rx_valid,
  input wire uart_pkg::uart_byte_t rx_data,
  output hand_pkg::hand_coord_t hand_out, // meaningful while hand_valid is high
  output logic hand_valid,
  output logic frame_error,
  output hand_pkg::hand_coord_t shown // last good coordinate
);
  import uart_pkg::*;
  import hand_pkg::*;

  typedef enum logic [1:0] {
    st_hunt,
    st_payload,
    st_check
  } df_state_t;

  df_state_t state;
  logic [1:0] pay_idx;
  uart_byte_t pay [frame_payload_len];
  uart_byte_t run_xor; // xor of payload so far

  // undo the byte packing, the zero pad bits are dropped
  assign hand_out.y = {pay[0][3:0], pay[1]};
  assign hand_out.z = {pay[2][5:0], pay[3]};

  always_ff @(posedge clk_65mhz or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_hunt;
      pay_idx <= '0;
      hand_valid <= 1'b0;
      frame_error <= 1'b0;
      shown <= '0;
    end else begin
      hand_valid <= 1'b0;
      frame_error <= 1'b0;
      if (rx_valid) begin
        case (state)
          st_hunt: if (rx_data == frame_header) begin // anything else is junk
            state <= st_payload;
            pay_idx <= '0;
          end
          st_payload: begin
            pay_idx <= pay_idx + 1'b1;
            if (pay_idx == 2'(frame_payload_len - 1)) state <= st_check;
          end
          st_check: begin
            state <= st_hunt; // good or bad, look for the next header
            if (rx_data == run_xor) begin
              hand_valid <= 1'b1;
              shown <= hand_out;
            end else begin
              frame_error <= 1'b1;
            end
          end
          default: state <= st_hunt;
        endcase
      end
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (rx_valid && state == st_hunt) run_xor <= '0;
    if (rx_valid && state == st_payload) begin
      pay[pay_idx] <= rx_data;
      run_xor <= run_xor ^ rx_data;
    end
  end

endmodule

`default_nettype wire

// File: source/coord_framer.sv
`default_nettype none

module coord_framer (
  input wire clk_65mhz,
  input wire rst_n,
  input wire send, // one-cycle request, dropped while frame_busy
  input wire hand_pkg::hand_coord_t hand_in,
  input wire byte_busy, // from the transmitter
  output logic tx_start,
  output uart_pkg::uart_byte_t tx_data,
  output logic frame_busy
);
  import uart_pkg::*;
  import hand_pkg::*;

  hand_coord_t coord_q; // coordinate frozen for the whole frame
  uart_byte_t pay [frame_payload_len];
  uart_byte_t checksum;
  uart_byte_t next_byte;
  logic [2:0] byte_idx; // 0 header, 1..4 payload, 5 checksum
  logic last; // all bytes handed over
  logic byte_idle; // transmitter free and no strobe in flight
  logic issue;

  assign pay[0] = {4'h0, coord_q.y[11:8]};
  assign pay[1] = coord_q.y[7:0];
  assign pay[2] = {2'b00, coord_q.z[13:8]};
  assign pay[3] = coord_q.z[7:0];
  assign checksum = pay[0] ^ pay[1] ^ pay[2] ^ pay[3];

  assign last = (byte_idx == 3'(frame_len));
  assign byte_idle = !byte_busy && !tx_start; // busy rises a cycle after the strobe
  assign issue = frame_busy && byte_idle && !last;

  always_comb begin
    case (byte_idx)
      3'd0: next_byte = frame_header;
      3'd5: next_byte = checksum;
      default: next_byte = pay[2'(byte_idx - 3'd1)];
    endcase
  end

  always_ff @(posedge clk_65mhz or negedge rst_n) begin
    if (!rst_n) begin
      frame_busy <= 1'b0;
      tx_start <= 1'b0;
      byte_idx <= '0;
    end else begin
      tx_start <= 1'b0;
      if (!frame_busy) begin
        byte_idx <= '0;
        frame_busy <= send;
      end else if (issue) begin
        tx_start <= 1'b1;
        byte_idx <= byte_idx + 1'b1;
      end else if (byte_idle && last) begin
        frame_busy <= 1'b0; // checksum byte fully out
      end
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (send && !frame_busy) coord_q <= hand_in;
    if (issue) tx_data <= next_byte; // lands with tx_start
  end

endmodule

`default_nettype wire

// File: source/uart_transmitter.sv
`default_nettype none

module uart_transmitter #(
  parameter int clks_per_bit = uart_pkg::clks_per_bit_default
) (
  input wire clk_65mhz,
  input wire rst_n,
  input wire tx_start, // one-cycle strobe, ignored while busy
  input wire uart_pkg::uart_byte_t tx_data,
  output logic txd,
  output logic tx_busy
);
  import uart_pkg::*;

  logic [bit_cnt_w-1:0] bit_timer;
  logic [3:0] bit_num; // 0 is start, 9 is stop
  logic tail; // idle cycle after stop bit, still busy
  logic [8:0] shifter; // data bits then stop bit
  logic bit_end;

  assign bit_end = tx_busy && !tail && (bit_timer == bit_cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk_65mhz or negedge rst_n) begin
    if (!rst_n) begin
      txd <= 1'b1; // line idles high
      tx_busy <= 1'b0;
      tail <= 1'b0;
      bit_timer <= '0;
      bit_num <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        txd <= 1'b0; // start bit goes out right away
        tx_busy <= 1'b1;
        bit_timer <= '0;
        bit_num <= '0;
      end
    end else if (tail) begin
      tx_busy <= 1'b0;
      tail <= 1'b0;
    end else if (bit_end) begin
      bit_timer <= '0;
      if (bit_num == 4'd9) begin
        tail <= 1'b1; // stop bit done
        txd <= 1'b1;
      end else begin
        txd <= shifter[0];
        bit_num <= bit_num + 1'b1;
      end
    end else begin
      bit_timer <= bit_timer + 1'b1;
    end
  end

  // shifts in ones from the top, so the stop bit falls out last
  always_ff @(posedge clk_65mhz) begin
    if (tx_start && !tx_busy) shifter <= {1'b1, tx_data};
    else if (bit_end) shifter <= {1'b1, shifter[8:1]};
  end

endmodule

`default_nettype wire

// File: source/uart_receiver.sv
`default_nettype none

module uart_receiver #(
  parameter int clks_per_bit = uart_pkg::clks_per_bit_default
) (
  input wire clk_65mhz,
  input wire rst_n,
  input wire rxd, // raw serial in, asynchronous
  output uart_pkg::uart_byte_t rx_data,
  output logic rx_valid // one cycle per good byte
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t state;
  logic rx_meta, rx_sync, rx_prev; // two-flop sync plus edge history
  logic [bit_cnt_w-1:0] bit_timer;
  logic [2:0] bit_num;
  uart_byte_t shifter;
  logic half_tick, full_tick;

  assign half_tick = (bit_timer == bit_cnt_w'(clks_per_bit / 2 - 1)); // middle of start bit
  assign full_tick = (bit_timer == bit_cnt_w'(clks_per_bit - 1)); // one bit later

  // line idles high, so sync flops come out of reset high
  always_ff @(posedge clk_65mhz or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rxd;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk_65mhz or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      bit_timer <= '0;
      bit_num <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      bit_timer <= bit_timer + 1'b1;
      case (state)
        st_idle: begin
          bit_timer <= '0;
          if (rx_prev && !rx_sync) state <= st_start; // falling edge
        end
        st_start: if (half_tick) begin
          bit_timer <= '0;
          bit_num <= '0;
          state <= rx_sync ? st_idle : st_data; // glitch if line went back high
        end
        st_data: if (full_tick) begin
          bit_timer <= '0;
          bit_num <= bit_num + 1'b1;
          if (bit_num == 3'd7) state <= st_stop;
        end
        st_stop: if (full_tick) begin
          state <= st_idle; // back to idle at mid stop bit
          rx_valid <= rx_sync; // framing error drops the byte
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk_65mhz) begin
    if (state == st_data && full_tick) shifter <= {rx_sync, shifter[7:1]};
    if (state == st_stop && full_tick && rx_sync) rx_data <= shifter;
  end

endmodule

`default_nettype wire

// File: source/hand_pkg.sv
`default_nettype none

package hand_pkg;

  typedef logic [11:0] coord_y_t; // vertical position in pixels
  typedef logic [13:0] coord_z_t; // depth estimate

  // y sits above z, 26 bits in all
  typedef struct packed {
    coord_y_t y;
    coord_z_t z;
  } hand_coord_t;

  // sync byte, chosen so it rarely shows up in idle noise
  localparam uart_pkg::uart_byte_t frame_header = 8'hA5;

  // payload is {0,y_hi} y_lo {0,z_hi} z_lo
  localparam int frame_payload_len = 4;

  // header + payload + xor checksum
  localparam int frame_len = frame_payload_len + 2;

endpackage

`default_nettype wire

// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // one data byte on the serial line
  typedef logic [7:0] uart_byte_t;

  // 65 MHz / 115200 baud, rounded down
  localparam int clks_per_bit_default = 564;

  // bit timer width, sized for the default rate
  localparam int bit_cnt_w = $clog2(clks_per_bit_default);

endpackage

`default_nettype wire
